//--- common/raster_pkg.sv
package raster_pkg;

    // screen geometry
    localparam int screen_w = 320;
    localparam int screen_h = 240;

    // row adder split, five segments of 64 pixels
    localparam int seg_w   = 64;
    localparam int num_seg = 5;

    localparam int num_edges = 4;

    // edge function width, 19-bit two's complement that wraps
    localparam int ef_w = 19;

    // vertex coordinate, 0..1023 representable
    typedef logic [9:0] coord_t;

    // scanline index 0..239
    typedef logic [7:0] line_t;

    // edge deltas, x difference kept at 9 bits
    typedef logic [8:0] delta_x_t;
    typedef logic [9:0] delta_y_t;

    // edge value, msb is the sign used for coverage
    typedef logic [ef_w-1:0] edge_val_t;

    // four vertices, vertex i at bits 20*i, x in the low 10 bits
    typedef logic [num_edges*20-1:0] quad_t;

    // one bit per pixel, bit x for pixel x
    typedef logic [screen_w-1:0] mask_t;

    // control fsm
    typedef enum logic [1:0]
    {
        st_idle,
        st_run,
        st_drain
    } ctrl_state_t;

endpackage

//--- src/raster_ctrl.sv
`timescale 1ns/1ps

module raster_ctrl
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              load,
    output logic              line_issue,
    output raster_pkg::line_t line_y,
    output logic              busy,
    output logic              done
);

    raster_pkg::ctrl_state_t state;

    // set in the second drain cycle when the last line leaves coverage
    logic drain_cnt;

    // start only taken while idle
    assign load       = start && (state == raster_pkg::st_idle);
    assign line_issue = (state == raster_pkg::st_run);
    assign busy       = (state != raster_pkg::st_idle);
    assign done       = (state == raster_pkg::st_drain) && drain_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= raster_pkg::st_idle;
            line_y    <= '0;
            drain_cnt <= 1'b0;
        end
        else
        begin
            case (state)
                raster_pkg::st_idle:
                begin
                    // edge setup loads y = 0 values in this same cycle
                    if (load)
                    begin
                        state  <= raster_pkg::st_run;
                        line_y <= '0;
                    end
                end
                raster_pkg::st_run:
                begin
                    // one line per clock with no back-pressure
                    if (line_y == raster_pkg::line_t'(raster_pkg::screen_h - 1))
                    begin
                        state     <= raster_pkg::st_drain;
                        drain_cnt <= 1'b0;
                    end
                    else
                    begin
                        line_y <= line_y + 1'b1;
                    end
                end
                raster_pkg::st_drain:
                begin
                    // row register and then mask register take two cycles
                    if (drain_cnt)
                        state <= raster_pkg::st_idle;
                    else
                        drain_cnt <= 1'b1;
                end
                default:
                begin
                    state <= raster_pkg::st_idle;
                end
            endcase
        end
    end

    // issued lines stay on screen
    a_line_range: assert property (@(posedge clk) disable iff (!rst_n)
        line_issue |-> (line_y < raster_pkg::line_t'(raster_pkg::screen_h)));

    // issue runs unbroken and advances by one until line 239
    a_line_seq: assert property (@(posedge clk) disable iff (!rst_n)
        line_issue && (line_y != raster_pkg::line_t'(raster_pkg::screen_h - 1)) |=>
            line_issue && (line_y == $past(line_y) + 1'b1));

    // busy holds through done with no second load
    a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> (busy && !load && !done) [*241] ##1 (busy && done && !load));

endmodule

//--- src/edge_setup.sv
`timescale 1ns/1ps

module edge_setup
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic                   line_issue,
    input  raster_pkg::quad_t      vertices,
    output raster_pkg::edge_val_t  line_left [raster_pkg::num_edges],
    output raster_pkg::delta_y_t   dy        [raster_pkg::num_edges]
);

    // unpacked vertex coordinates
    raster_pkg::coord_t    vx     [raster_pkg::num_edges];
    raster_pkg::coord_t    vy     [raster_pkg::num_edges];

    // deltas and y = 0 left value, before the load register
    raster_pkg::delta_x_t  dx_c   [raster_pkg::num_edges];
    raster_pkg::delta_y_t  dy_c   [raster_pkg::num_edges];
    raster_pkg::edge_val_t left_c [raster_pkg::num_edges];

    // dx stays here, only the line step needs it
    raster_pkg::delta_x_t  dx_q   [raster_pkg::num_edges];

    always_comb
    begin
        for (int i = 0; i < raster_pkg::num_edges; i++)
        begin
            vx[i] = vertices[20*i +: 10];
            vy[i] = vertices[20*i + 10 +: 10];
        end

        // edges wired 0->1->2->3->0, counter-clockwise
        for (int i = 0; i < raster_pkg::num_edges; i++)
        begin
            dx_c[i] = raster_pkg::delta_x_t'(vx[(i + 1) % raster_pkg::num_edges] - vx[i]);
            dy_c[i] = raster_pkg::delta_y_t'(vy[(i + 1) % raster_pkg::num_edges] - vy[i]);

            // E(0, 0) = -x*dy + y*dx, deltas sign extended, product wraps at 19 bits
            left_c[i] = raster_pkg::edge_val_t'(vy[i]) *
                            raster_pkg::edge_val_t'($signed(dx_c[i]))
                      - raster_pkg::edge_val_t'(vx[i]) *
                            raster_pkg::edge_val_t'($signed(dy_c[i]));
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < raster_pkg::num_edges; i++)
            begin
                dx_q[i]      <= '0;
                dy[i]        <= '0;
                line_left[i] <= '0;
            end
        end
        else if (load)
        begin
            dx_q      <= dx_c;
            dy        <= dy_c;
            line_left <= left_c;
        end
        else if (line_issue)
        begin
            // next scanline, E(0, y+1) = E(0, y) - dx
            for (int i = 0; i < raster_pkg::num_edges; i++)
                line_left[i] <= line_left[i] - raster_pkg::edge_val_t'($signed(dx_q[i]));
        end
    end

endmodule

//--- edge_eval/edge_eval_row.sv
`timescale 1ns/1ps

module edge_eval_row
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   line_issue,
    input  raster_pkg::line_t      line_y,
    input  raster_pkg::edge_val_t  line_left [raster_pkg::num_edges],
    input  raster_pkg::delta_y_t   dy        [raster_pkg::num_edges],
    output raster_pkg::edge_val_t  row_vals  [raster_pkg::num_edges][raster_pkg::screen_w],
    output logic                   row_valid,
    output raster_pkg::line_t      row_y
);

    // dy widened to the edge width
    raster_pkg::edge_val_t dy_ext   [raster_pkg::num_edges];

    // value at the first pixel of each segment
    raster_pkg::edge_val_t seg_base [raster_pkg::num_edges][raster_pkg::num_seg];

    raster_pkg::edge_val_t row_c    [raster_pkg::num_edges][raster_pkg::screen_w];

    always_comb
    begin
        for (int i = 0; i < raster_pkg::num_edges; i++)
        begin
            dy_ext[i] = raster_pkg::edge_val_t'($signed(dy[i]));

            // left + 64*j*dy, one multiply per segment
            for (int j = 0; j < raster_pkg::num_seg; j++)
                seg_base[i][j] = line_left[i] +
                                 raster_pkg::edge_val_t'(raster_pkg::seg_w * j) * dy_ext[i];

            for (int j = 0; j < raster_pkg::num_seg; j++)
            begin
                row_c[i][j*raster_pkg::seg_w] = seg_base[i][j];

                // log-depth tree, level l fills offsets 2^l..2^(l+1)-1
                // from the earlier half plus dy shifted by l
                for (int l = 0; l < $clog2(raster_pkg::seg_w); l++)
                begin
                    for (int k = (1 << l); k < (2 << l); k++)
                        row_c[i][j*raster_pkg::seg_w + k] =
                            row_c[i][j*raster_pkg::seg_w + k - (1 << l)] + (dy_ext[i] << l);
                end
            end
        end
    end

    // row values, captured once per issued line
    always_ff @(posedge clk)
    begin
        if (line_issue)
            row_vals <= row_c;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_valid <= 1'b0;
            row_y     <= '0;
        end
        else
        begin
            row_valid <= line_issue;
            // y tag travels with its row
            if (line_issue)
                row_y <= line_y;
        end
    end

endmodule

//--- edge_eval/quad_coverage.sv
`timescale 1ns/1ps

module quad_coverage
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  raster_pkg::edge_val_t  row_vals [raster_pkg::num_edges][raster_pkg::screen_w],
    input  logic                   row_valid,
    input  raster_pkg::line_t      row_y,
    output raster_pkg::mask_t      mask,
    output logic                   line_valid,
    output raster_pkg::line_t      line_y_out
);

    localparam int sign_bit = raster_pkg::ef_w - 1;

    raster_pkg::mask_t mask_c;

    // inside when edges 0 and 1 are non-negative and edges 2 and 3 negative
    // (same sign pattern as the counter-clockwise winding of the host)
    always_comb
    begin
        for (int x = 0; x < raster_pkg::screen_w; x++)
        begin
            mask_c[x] = !row_vals[0][x][sign_bit] &&
                        !row_vals[1][x][sign_bit] &&
                         row_vals[2][x][sign_bit] &&
                         row_vals[3][x][sign_bit];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mask       <= '0;
            line_valid <= 1'b0;
            line_y_out <= '0;
        end
        else
        begin
            line_valid <= row_valid;
            // mask and y hold between lines
            if (row_valid)
            begin
                mask       <= mask_c;
                line_y_out <= row_y;
            end
        end
    end

    // back to back beats step y by one, or wrap 239 to 0 for a new quad
    a_line_order: assert property (@(posedge clk) disable iff (!rst_n)
        (line_valid ##1 line_valid) |->
            (line_y_out == $past(line_y_out) + 1'b1) ||
            ((line_y_out == '0) &&
             ($past(line_y_out) == raster_pkg::line_t'(raster_pkg::screen_h - 1))));

endmodule

//--- src/quad_raster_top.sv
`timescale 1ns/1ps

module quad_raster_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  raster_pkg::quad_t vertices,
    output logic              busy,
    output logic              done,
    output logic              line_valid,
    output raster_pkg::line_t line_y_out,
    output raster_pkg::mask_t mask
);

    // control to setup and row stage
    logic                  load;
    logic                  line_issue;
    raster_pkg::line_t     line_y;

    // per-line edge state
    raster_pkg::edge_val_t line_left [raster_pkg::num_edges];
    raster_pkg::delta_y_t  dy        [raster_pkg::num_edges];

    // row stage to coverage
    raster_pkg::edge_val_t row_vals  [raster_pkg::num_edges][raster_pkg::screen_w];
    logic                  row_valid;
    raster_pkg::line_t     row_y;

    raster_ctrl u_ctrl
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load       (load),
        .line_issue (line_issue),
        .line_y     (line_y),
        .busy       (busy),
        .done       (done)
    );

    edge_setup u_setup
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .line_issue (line_issue),
        .vertices   (vertices),
        .line_left  (line_left),
        .dy         (dy)
    );

    // first pipeline stage, registered per-pixel edge values
    edge_eval_row u_row
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_issue (line_issue),
        .line_y     (line_y),
        .line_left  (line_left),
        .dy         (dy),
        .row_vals   (row_vals),
        .row_valid  (row_valid),
        .row_y      (row_y)
    );

    // second stage, registered mask
    quad_coverage u_cov
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_vals   (row_vals),
        .row_valid  (row_valid),
        .row_y      (row_y),
        .mask       (mask),
        .line_valid (line_valid),
        .line_y_out (line_y_out)
    );

endmodule

//--- testbench/raster_ref_model.svh
`ifndef raster_ref_model_svh
`define raster_ref_model_svh

// 32-bit fibonacci lfsr, taps 32 22 2 1
// the new bit enters at the bottom, one step per bit drawn
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// x delta held in 9 bits, then sign extended
function automatic int model_dx(input int xa, input int xb);
    int       diff;
    logic [8:0] d;
    diff = xb - xa;
    d    = diff[8:0];
    return $signed(d);
endfunction

// y delta held in 10 bits
function automatic int model_dy(input int ya, input int yb);
    int       diff;
    logic [9:0] d;
    diff = yb - ya;
    d    = diff[9:0];
    return $signed(d);
endfunction

// E(x, y) = (x - xi)*dy - (y - yi)*dx, kept to the low 19 bits
function automatic raster_pkg::edge_val_t model_edge(input int x, input int y, input int xi,
                                                     input int yi, input int dx, input int dy);
    int e;
    e = (x - xi) * dy - (y - yi) * dx;
    return e[raster_pkg::ef_w-1:0];
endfunction

// one scanline of coverage, edges run 0->1->2->3->0
function automatic raster_pkg::mask_t model_mask(input raster_pkg::quad_t q, input int y);
    int vx  [raster_pkg::num_edges];
    int vy  [raster_pkg::num_edges];
    int ddx [raster_pkg::num_edges];
    int ddy [raster_pkg::num_edges];
    logic [raster_pkg::num_edges-1:0] neg;
    raster_pkg::edge_val_t e;
    raster_pkg::mask_t m;
    for (int i = 0; i < raster_pkg::num_edges; i++)
    begin
        vx[i] = q[20*i +: 10];
        vy[i] = q[20*i + 10 +: 10];
    end
    for (int i = 0; i < raster_pkg::num_edges; i++)
    begin
        ddx[i] = model_dx(vx[i], vx[(i + 1) % raster_pkg::num_edges]);
        ddy[i] = model_dy(vy[i], vy[(i + 1) % raster_pkg::num_edges]);
    end
    for (int x = 0; x < raster_pkg::screen_w; x++)
    begin
        for (int i = 0; i < raster_pkg::num_edges; i++)
        begin
            e      = model_edge(x, y, vx[i], vy[i], ddx[i], ddy[i]);
            neg[i] = e[raster_pkg::ef_w-1];
        end
        // edges 0 and 1 non-negative, edges 2 and 3 negative
        m[x] = !neg[0] && !neg[1] && neg[2] && neg[3];
    end
    return m;
endfunction

`endif

//--- testbench/tb_quad_raster.sv
`timescale 1ns/1ps

module tb_quad_raster;

    `include "raster_ref_model.svh"

    localparam int clk_period = 8;
    // line 239 leaves the pipeline this many cycles after the start is sampled
    localparam int last_lat   = raster_pkg::screen_h + 2;
    localparam int run_cycles = last_lat + 20;
    // idle plus 30 random, rectangle, latency, ignored start and three back to back
    localparam int num_runs   = 37;
    localparam int rect_l = 40;
    localparam int rect_t = 60;
    localparam int rect_r = 200;
    localparam int rect_b = 180;

    logic              clk;
    logic              rst_n;
    logic              start;
    raster_pkg::quad_t vertices;
    logic              busy;
    logic              done;
    logic              line_valid;
    raster_pkg::line_t line_y_out;
    raster_pkg::mask_t mask;

    logic [31:0] lfsr = 32'h2301;
    int cycle = 0;
    int test_err;
    int total_err = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // monitor history indexed by cycle
    raster_pkg::mask_t beat_mask [$];
    int                beat_y    [$];
    int                beat_cyc  [$];
    bit                busy_hist [$];
    bit                done_hist [$];
    raster_pkg::mask_t exp_mask  [raster_pkg::screen_h];

    quad_raster_top u_dut
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .vertices   (vertices),
        .busy       (busy),
        .done       (done),
        .line_valid (line_valid),
        .line_y_out (line_y_out),
        .mask       (mask)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // samples the values of the cycle that just ended
    always @(posedge clk)
    begin
        busy_hist.push_back(busy);
        done_hist.push_back(done);
        if (line_valid)
        begin
            beat_mask.push_back(mask);
            beat_y.push_back(line_y_out);
            beat_cyc.push_back(cycle);
        end
        cycle <= cycle + 1;
    end

    initial
    begin
        #((num_runs * run_cycles + 16) * clk_period);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    // draw n bits per try and retry until below limit
    function automatic int draw(input int n, input int limit);
        int v;
        do
        begin
            v = 0;
            for (int b = 0; b < n; b++)
            begin
                lfsr = lfsr_next(lfsr);
                v = (v << 1) | lfsr[0];
            end
        end while (v >= limit);
        return v;
    endfunction

    function automatic raster_pkg::quad_t random_quad();
        raster_pkg::quad_t q;
        for (int i = 0; i < raster_pkg::num_edges; i++)
        begin
            q[20*i +: 10]      = draw(9, raster_pkg::screen_w);
            q[20*i + 10 +: 10] = draw(8, raster_pkg::screen_h);
        end
        return q;
    endfunction

    task automatic expect_model(input raster_pkg::quad_t q);
        for (int y = 0; y < raster_pkg::screen_h; y++)
            exp_mask[y] = model_mask(q, y);
    endtask

    // rectangle a(l,t) b(r,t) c(r,b) d(l,b) with half planes from the sign rule
    // e0 >= 0 for y <= t and e1 >= 0 for x >= r
    // e2 < 0 for y < b and e3 < 0 for x > l
    task automatic expect_rect();
        for (int y = 0; y < raster_pkg::screen_h; y++)
            for (int x = 0; x < raster_pkg::screen_w; x++)
                exp_mask[y][x] = (y <= rect_t) && (x >= rect_r) && (y < rect_b) && (x > rect_l);
    endtask

    // drives from the current rising edge and returns at the edge that samples it
    task automatic pulse_start(input raster_pkg::quad_t q);
        start    <= 1'b1;
        vertices <= q;
        @(posedge clk);
        start    <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end while (!done && n < run_cycles);
        assert (done) else
        begin
            $display("no done within %0d cycles in test %s", run_cycles, name);
            test_err++;
        end
    endtask

    // s is the cycle in which the dut sampled the accepted start
    task automatic check_quad(input string name, input int s);
        int lows;
        int dones;
        assert (beat_mask.size() == raster_pkg::screen_h) else
        begin
            $display("mismatch %s beats: expected %0d actual %0d", name,
                     raster_pkg::screen_h, beat_mask.size());
            test_err++;
        end
        for (int k = 0; k < raster_pkg::screen_h && beat_mask.size() > 0; k++)
        begin
            assert (beat_y[0] == k) else
            begin
                $display("mismatch %s line_y: expected %0d actual %0d", name, k, beat_y[0]);
                test_err++;
            end
            assert (beat_cyc[0] == s + 3 + k) else
            begin
                $display("mismatch %s line %0d cycle: expected %0d actual %0d", name, k,
                         s + 3 + k, beat_cyc[0]);
                test_err++;
            end
            assert (beat_mask[0] == exp_mask[k]) else
            begin
                $display("mismatch %s line %0d mask: expected %h actual %h", name, k,
                         exp_mask[k], beat_mask[0]);
                test_err++;
            end
            void'(beat_mask.pop_front());
            void'(beat_y.pop_front());
            void'(beat_cyc.pop_front());
        end
        beat_mask.delete();
        beat_y.delete();
        beat_cyc.delete();
        lows  = 0;
        dones = 0;
        for (int c = s + 1; c <= s + last_lat; c++)
        begin
            lows  += !busy_hist[c];
            dones += done_hist[c];
        end
        assert (lows == 0) else
        begin
            $display("busy went low in %0d cycles of test %s", lows, name);
            test_err++;
        end
        assert (dones == 1 && done_hist[s + last_lat]) else
        begin
            $display("done did not pulse once with line 239 in test %s", name);
            test_err++;
        end
    endtask

    task automatic report(input string name);
        tests_run++;
        total_err += test_err;
        if (test_err == 0)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_err);
        end
    endtask

    // poke sends a second start with other vertices while busy
    task automatic run_one(input string name, input raster_pkg::quad_t q, input bit poke);
        int s;
        test_err = 0;
        @(posedge clk);
        pulse_start(q);
        s = cycle;
        if (poke)
        begin
            repeat (5) @(posedge clk);
            pulse_start(~q);
        end
        wait_done(name);
        @(negedge clk);
        check_quad(name, s);
        report(name);
    endtask

    // next start goes out in the cycle right after each done
    task automatic back_to_back();
        raster_pkg::quad_t qs [3];
        int s;
        test_err = 0;
        for (int k = 0; k < 3; k++)
            qs[k] = random_quad();
        @(posedge clk);
        pulse_start(qs[0]);
        s = cycle;
        for (int k = 0; k < 3; k++)
        begin
            wait_done("back_to_back");
            if (k < 2)
            begin
                start    <= 1'b1;
                vertices <= qs[k + 1];
            end
            @(negedge clk);
            expect_model(qs[k]);
            check_quad("back_to_back", s);
            if (k < 2)
            begin
                @(posedge clk);
                start <= 1'b0;
                s = cycle;
            end
        end
        report("back_to_back");
    endtask

    initial
    begin
        raster_pkg::quad_t q;
        rst_n    = 1'b0;
        start    = 1'b0;
        vertices = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // outputs stay quiet with no start
        test_err = 0;
        repeat (40)
        begin
            @(posedge clk);
            assert (!busy && !done && !line_valid && mask == '0) else
            begin
                $display("mismatch idle busy/done/valid/mask: expected 0000 actual %b%b%b%b",
                         busy, done, line_valid, |mask);
                test_err++;
            end
        end
        report("idle");

        for (int i = 0; i < 30; i++)
        begin
            q = random_quad();
            expect_model(q);
            run_one($sformatf("random_%0d", i), q, 1'b0);
        end

        expect_rect();
        run_one("rectangle", {10'd180, 10'd40, 10'd180, 10'd200, 10'd60, 10'd200,
                              10'd60, 10'd40}, 1'b0);

        q = random_quad();
        expect_model(q);
        run_one("latency", q, 1'b0);

        q = random_quad();
        expect_model(q);
        run_one("start_while_busy", q, 1'b1);

        back_to_back();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_err);
        if (total_err == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+testbench
common/raster_pkg.sv
src/raster_ctrl.sv
src/edge_setup.sv
edge_eval/edge_eval_row.sv
edge_eval/quad_coverage.sv
src/quad_raster_top.sv
testbench/tb_quad_raster.sv

//--- Bender.yml
package:
  name: quad_raster

sources:
  # design, package first
  - files:
      - common/raster_pkg.sv
      - src/raster_ctrl.sv
      - src/edge_setup.sv
      - edge_eval/edge_eval_row.sv
      - edge_eval/quad_coverage.sv
      - src/quad_raster_top.sv

  # testbench with its model header
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_quad_raster.sv
